// ==== verilog/sobel_config.svh ====
`ifndef SOBEL_CONFIG_SVH
`define SOBEL_CONFIG_SVH

// Camera pixel width
`define SOBEL_PIX_W 8

// Signed Gx or Gy partial sum width
`define SOBEL_SUM_W 16

// Window columns per tap memory
// Three pixels per window column, so lines up to 768 pixels
`define SOBEL_WIN_DEPTH 256

// Packed edge word width
`define SOBEL_WORD_W 32

// Kernel taps, one per row and column phase pair
`define SOBEL_TAPS 9

// Write flag bit in ciValueA, register select sits just above it
`define SOBEL_OP_LSB 9

`endif

// ==== verilog/sobelPkg.sv ====
`include "sobel_config.svh"

package sobelPkg;

    // Camera pixel
    typedef logic [`SOBEL_PIX_W-1:0] pixelT;

    // Signed running Gx or Gy sum
    typedef logic signed [`SOBEL_SUM_W-1:0] sumT;

    // Window column index into a tap memory
    typedef logic [$clog2(`SOBEL_WIN_DEPTH)-1:0] winIdxT;

    // Position of a column or row modulo 3
    typedef enum logic [1:0] {
        PHASE0,
        PHASE1,
        PHASE2
    } phaseT;

    // Custom instruction register select
    typedef enum logic [2:0] {
        REG_THRESHOLD = 3'b100,
        REG_CAPTURE   = 3'b101
    } ciRegT;

    // Edge threshold on |Gx|+|Gy|
    typedef logic [15:0] thresholdT;

endpackage

// ==== verilog/phaseTracker.sv ====
`timescale 1ns/1ps

module phaseTracker (
    input  logic            camClock,
    input  logic            rstN,
    input  logic            pixelValid,
    input  logic            hsync,
    input  logic            vsync,
    output sobelPkg::phaseT colPhase,
    output sobelPkg::phaseT rowPhase,
    output logic            pixelStep,
    output logic            lineStart,
    output logic            windowFull
);

    // Pixels seen in this line, saturates at 2
    logic [1:0] pixCount;
    // Rows seen in this frame, saturates at 2
    logic [1:0] rowCount;

    function automatic sobelPkg::phaseT nextPhase(input sobelPkg::phaseT p);
        case (p)
            sobelPkg::PHASE0: nextPhase = sobelPkg::PHASE1;
            sobelPkg::PHASE1: nextPhase = sobelPkg::PHASE2;
            default:          nextPhase = sobelPkg::PHASE0;
        endcase
    endfunction

    // Either sync restarts the column walk
    assign lineStart = hsync | vsync;

    // Pixel strobe to the taps, never taken together with a sync
    assign pixelStep = pixelValid & ~lineStart;

    // Two earlier pixels and two earlier rows give a full 3x3 window
    assign windowFull = (pixCount == 2'd2) && (rowCount == 2'd2);

    // Column phase of the pixel now on camData
    always_ff @(posedge camClock) begin
        if (!rstN || lineStart) begin
            colPhase <= sobelPkg::PHASE0;
            pixCount <= 2'd0;
        end else if (pixelStep) begin
            colPhase <= nextPhase(colPhase);
            if (pixCount != 2'd2) begin
                pixCount <= pixCount + 2'd1;
            end
        end
    end

    // Row phase, hsync closes a line
    always_ff @(posedge camClock) begin
        if (!rstN || vsync) begin
            rowPhase <= sobelPkg::PHASE0;
            rowCount <= 2'd0;
        end else if (hsync) begin
            rowPhase <= nextPhase(rowPhase);
            if (rowCount != 2'd2) begin
                rowCount <= rowCount + 2'd1;
            end
        end
    end

endmodule

// ==== verilog/sobelTap.sv ====
`timescale 1ns/1ps
`include "sobel_config.svh"

module sobelTap #(
    parameter int tapIndex = 0
) (
    input  logic            camClock,
    input  logic            rstN,
    input  logic            pixelStep,
    input  logic            lineStart,
    input  sobelPkg::phaseT colPhase,
    input  sobelPkg::phaseT rowPhase,
    input  sobelPkg::pixelT camData,
    output sobelPkg::sumT   sumX,
    output sobelPkg::sumT   sumY,
    output logic            windowDone
);

    // Phase of the top-left pixel of every window this tap owns
    localparam int ownRow = tapIndex / 3;
    localparam int ownCol = tapIndex % 3;

    // Taps not starting at column 0 see a partial lead-in window
    // It lands in the top slot so real windows start at slot 0
    localparam sobelPkg::winIdxT startIdx = (ownCol == 0) ? '0 : '1;

    // Running sums, one entry per window column
    sobelPkg::sumT memX [`SOBEL_WIN_DEPTH];
    sobelPkg::sumT memY [`SOBEL_WIN_DEPTH];

    sobelPkg::winIdxT   winIdx;
    logic [1:0]         dx;
    logic [1:0]         dy;
    logic signed [2:0]  wX;
    logic signed [2:0]  wY;
    logic               restart;
    sobelPkg::sumT      pixExt;
    sobelPkg::sumT      termX;
    sobelPkg::sumT      termY;

    function automatic sobelPkg::sumT weigh(input sobelPkg::sumT pix, input logic signed [2:0] w);
        case (w)
            3'sd1:   weigh = pix;
            3'sd2:   weigh = pix <<< 1;
            -3'sd1:  weigh = -pix;
            -3'sd2:  weigh = -(pix <<< 1);
            default: weigh = '0;
        endcase
    endfunction

    // Offset of the current pixel inside the owned window
    assign dy = 2'((int'(rowPhase) + 3 - ownRow) % 3);
    assign dx = 2'((int'(colPhase) + 3 - ownCol) % 3);

    // Kernel weights by offset
    always_comb begin
        case (dx)
            2'd0:    wX = (dy == 2'd1) ? -3'sd2 : -3'sd1;
            2'd2:    wX = (dy == 2'd1) ? 3'sd2 : 3'sd1;
            default: wX = 3'sd0;
        endcase
        case (dy)
            2'd0:    wY = (dx == 2'd1) ? 3'sd2 : 3'sd1;
            2'd2:    wY = (dx == 2'd1) ? -3'sd2 : -3'sd1;
            default: wY = 3'sd0;
        endcase
    end

    // Pixel is unsigned, widen with zeros
    assign pixExt = sobelPkg::sumT'({1'b0, camData});
    assign termX  = weigh(pixExt, wX);
    assign termY  = weigh(pixExt, wY);

    // Top-left pixel throws away whatever the slot held
    assign restart = (dx == 2'd0) && (dy == 2'd0);

    assign sumX = restart ? termX : memX[winIdx] + termX;
    assign sumY = restart ? termY : memY[winIdx] + termY;

    // Bottom-right pixel completes the window
    assign windowDone = pixelStep && (dx == 2'd2) && (dy == 2'd2);

    always_ff @(posedge camClock) begin
        if (pixelStep) begin
            memX[winIdx] <= sumX;
            memY[winIdx] <= sumY;
        end
    end

    // Move to the next window after its last column
    always_ff @(posedge camClock) begin
        if (!rstN || lineStart) begin
            winIdx <= startIdx;
        end else if (pixelStep && dx == 2'd2) begin
            winIdx <= winIdx + 1'b1;
        end
    end

endmodule

// ==== verilog/edgePacker.sv ====
`timescale 1ns/1ps
`include "sobel_config.svh"

module edgePacker (
    input  logic                     camClock,
    input  logic                     rstN,
    input  logic                     pixelStep,
    input  logic                     lineStart,
    input  logic                     windowFull,
    input  logic                     captureActive,
    input  sobelPkg::sumT            sumX [`SOBEL_TAPS],
    input  sobelPkg::sumT            sumY [`SOBEL_TAPS],
    input  logic [`SOBEL_TAPS-1:0]   windowDone,
    input  sobelPkg::thresholdT      threshold,
    output logic [`SOBEL_WORD_W-1:0] edgeWord,
    output logic                     wordValid
);

    sobelPkg::sumT                     selX;
    sobelPkg::sumT                     selY;
    logic [`SOBEL_SUM_W-1:0]           absX;
    logic [`SOBEL_SUM_W-1:0]           absY;
    logic [`SOBEL_SUM_W:0]             magnitude;
    logic                              overThreshold;
    logic                              edgeBit;
    logic                              stepD;
    logic [$clog2(`SOBEL_WORD_W)-1:0]  groupCount;

    // Only one tap finishes a window per pixel
    always_comb begin
        selX = '0;
        selY = '0;
        for (int t = 0; t < `SOBEL_TAPS; t++) begin
            if (windowDone[t]) begin
                selX = sumX[t];
                selY = sumY[t];
            end
        end
    end

    // |Gx|+|Gy| with one spare bit
    assign absX = selX[`SOBEL_SUM_W-1] ? -selX : selX;
    assign absY = selY[`SOBEL_SUM_W-1] ? -selY : selY;
    assign magnitude = {1'b0, absX} + {1'b0, absY};
    assign overThreshold = magnitude > {1'b0, threshold};

    // Border pixels without a full window give 0
    always_ff @(posedge camClock) begin
        if (pixelStep) begin
            edgeBit <= windowFull && overThreshold;
        end
    end

    // First pixel of a group ends up in the MSB
    always_ff @(posedge camClock) begin
        if (stepD) begin
            edgeWord <= {edgeWord[`SOBEL_WORD_W-2:0], edgeBit};
        end
    end

    // Group counter and word strobe
    always_ff @(posedge camClock) begin
        if (!rstN) begin
            stepD      <= 1'b0;
            groupCount <= '0;
            wordValid  <= 1'b0;
        end else begin
            stepD     <= pixelStep;
            wordValid <= 1'b0;
            if (lineStart) begin
                // drop any partial group
                groupCount <= '0;
            end else if (stepD) begin
                groupCount <= groupCount + 1'b1;
                wordValid  <= captureActive && (groupCount == '1);
            end
        end
    end

endmodule

// ==== verilog/controlRegs.sv ====
`timescale 1ns/1ps
`include "sobel_config.svh"

module controlRegs #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic                camClock,
    input  logic                rstN,
    input  logic                ciStart,
    input  logic                frameStart,
    input  logic [7:0]          ciN,
    input  logic [31:0]         ciValueA,
    input  logic [31:0]         ciValueB,
    output logic [31:0]         ciResult,
    output logic                ciDone,
    output sobelPkg::thresholdT threshold,
    output logic                captureActive
);

    logic            validInstr;
    logic            writeFlag;
    sobelPkg::ciRegT regSel;
    logic            armed;

    // Only our instruction number answers
    assign validInstr = ciStart && (ciN == customId);
    assign ciDone     = validInstr;

    assign writeFlag = ciValueA[`SOBEL_OP_LSB];
    assign regSel    = sobelPkg::ciRegT'(ciValueA[`SOBEL_OP_LSB+1 +: 3]);

    // Reads only, writes return 0
    always_comb begin
        ciResult = 32'd0;
        if (validInstr && !writeFlag) begin
            case (regSel)
                sobelPkg::REG_THRESHOLD: ciResult = {16'd0, threshold};
                sobelPkg::REG_CAPTURE:   ciResult = {30'd0, captureActive, armed};
                default:                 ciResult = 32'd0;
            endcase
        end
    end

    always_ff @(posedge camClock) begin
        if (!rstN) begin
            threshold <= '0;
        end else if (validInstr && writeFlag && regSel == sobelPkg::REG_THRESHOLD) begin
            threshold <= ciValueB[15:0];
        end
    end

    // One-shot capture
    // Armed waits for vsync, then covers exactly that frame
    always_ff @(posedge camClock) begin
        if (!rstN) begin
            armed         <= 1'b0;
            captureActive <= 1'b0;
        end else begin
            if (validInstr && writeFlag && regSel == sobelPkg::REG_CAPTURE) begin
                armed <= 1'b1;
            end else if (frameStart) begin
                armed <= 1'b0;
            end
            if (frameStart) begin
                captureActive <= armed;
            end
        end
    end

endmodule

// ==== verilog/sobelTop.sv ====
`timescale 1ns/1ps
`include "sobel_config.svh"

module sobelTop #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic                     camClock,
    input  logic                     rstN,
    input  sobelPkg::pixelT          camData,
    input  logic                     pixelValid,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     ciStart,
    input  logic [7:0]               ciN,
    input  logic [31:0]              ciValueA,
    input  logic [31:0]              ciValueB,
    output logic [31:0]              ciResult,
    output logic                     ciDone,
    output logic [`SOBEL_WORD_W-1:0] edgeWord,
    output logic                     wordValid
);

    sobelPkg::phaseT       colPhase;
    sobelPkg::phaseT       rowPhase;
    logic                  pixelStep;
    logic                  lineStart;
    logic                  windowFull;
    sobelPkg::sumT         sumX [`SOBEL_TAPS];
    sobelPkg::sumT         sumY [`SOBEL_TAPS];
    logic [`SOBEL_TAPS-1:0] windowDone;
    sobelPkg::thresholdT   threshold;
    logic                  captureActive;

    // Row and column phases of the incoming pixel
    phaseTracker tracker (
        .camClock   (camClock),
        .rstN       (rstN),
        .pixelValid (pixelValid),
        .hsync      (hsync),
        .vsync      (vsync),
        .colPhase   (colPhase),
        .rowPhase   (rowPhase),
        .pixelStep  (pixelStep),
        .lineStart  (lineStart),
        .windowFull (windowFull)
    );

    // One tap per window phase, all fed the same pixel
    for (genvar i = 0; i < `SOBEL_TAPS; i++) begin : genTap
        sobelTap #(.tapIndex(i)) tap (
            .camClock   (camClock),
            .rstN       (rstN),
            .pixelStep  (pixelStep),
            .lineStart  (lineStart),
            .colPhase   (colPhase),
            .rowPhase   (rowPhase),
            .camData    (camData),
            .sumX       (sumX[i]),
            .sumY       (sumY[i]),
            .windowDone (windowDone[i])
        );
    end

    edgePacker packer (
        .camClock      (camClock),
        .rstN          (rstN),
        .pixelStep     (pixelStep),
        .lineStart     (lineStart),
        .windowFull    (windowFull),
        .captureActive (captureActive),
        .sumX          (sumX),
        .sumY          (sumY),
        .windowDone    (windowDone),
        .threshold     (threshold),
        .edgeWord      (edgeWord),
        .wordValid     (wordValid)
    );

    // Capture control runs off vsync directly
    controlRegs #(.customId(customId)) regs (
        .camClock      (camClock),
        .rstN          (rstN),
        .ciStart       (ciStart),
        .frameStart    (vsync),
        .ciN           (ciN),
        .ciValueA      (ciValueA),
        .ciValueB      (ciValueB),
        .ciResult      (ciResult),
        .ciDone        (ciDone),
        .threshold     (threshold),
        .captureActive (captureActive)
    );

endmodule

// ==== bench/sobel_chk.sv ====
`timescale 1ns/1ps

module sobelChk #(
    parameter bit packerSide = 1'b1
) (
    input logic camClock,
    input logic rstN,
    input logic wordValid,
    input logic captureActive,
    input logic ciStart,
    input logic ciDone
);

    // Failure tallies per property
    int strobeFails = 0;
    int doneFails = 0;
    int activeFails = 0;
    int failCount;

    assign failCount = strobeFails + doneFails + activeFails;

    // Each bound copy watches only the signals its host drives
    if (packerSide) begin : genPacker
        // Word strobe lasts one cycle
        assert property (@(posedge camClock) disable iff (!rstN) wordValid |=> !wordValid)
        else begin
            strobeFails = strobeFails + 1;
            $error("wordValid high on two consecutive cycles");
        end

        // Words only inside the captured frame
        assert property (@(posedge camClock) disable iff (!rstN) wordValid |-> captureActive)
        else begin
            activeFails = activeFails + 1;
            $error("wordValid high outside capture");
        end
    end else begin : genRegs
        // Done only answers a started instruction
        assert property (@(posedge camClock) disable iff (!rstN) ciDone |-> ciStart)
        else begin
            doneFails = doneFails + 1;
            $error("ciDone high without ciStart");
        end
    end

endmodule

bind edgePacker sobelChk #(.packerSide(1'b1)) packerChk (
    .camClock      (camClock),
    .rstN          (rstN),
    .wordValid     (wordValid),
    .captureActive (captureActive),
    .ciStart       (1'b0),
    .ciDone        (1'b0)
);

bind controlRegs sobelChk #(.packerSide(1'b0)) regsChk (
    .camClock      (camClock),
    .rstN          (rstN),
    .wordValid     (1'b0),
    .captureActive (captureActive),
    .ciStart       (ciStart),
    .ciDone        (ciDone)
);

// ==== bench/sobelTb.sv ====
`timescale 1ns/1ps
`include "sobel_config.svh"

module sobelTb;

    localparam int clkPeriod = 10;
    localparam logic [7:0] ourId = 8'd5;
    localparam int wordW = `SOBEL_WORD_W;
    localparam int cols = 64;
    localparam int rows = 6;
    // Idle cycles between last pixel and hsync
    localparam int lineGap = 6;
    // vsync, lead-in, lines with their hsync, tail
    localparam int frameCycles = 3 + rows * (cols + lineGap + 1) + 4;
    // Five frames over all tests
    localparam int watchdogNs = 4 * 5 * frameCycles * clkPeriod + 2000;

    logic camClock;
    logic rstN;
    sobelPkg::pixelT camData;
    logic pixelValid;
    logic hsync;
    logic vsync;
    logic ciStart;
    logic [7:0] ciN;
    logic [31:0] ciValueA;
    logic [31:0] ciValueB;
    logic [31:0] ciResult;
    logic ciDone;
    logic [wordW-1:0] edgeWord;
    logic wordValid;

    sobelPkg::pixelT image [rows][cols];
    logic [31:0] rngState;
    logic [wordW-1:0] gotWords [$];
    logic [wordW-1:0] expWords [$];
    int errorCount;
    int checkCount;

    sobelTop #(.customId(ourId)) dut (.*);

    initial begin
        camClock = 1'b0;
        forever #(clkPeriod / 2) camClock = ~camClock;
    end

    // Word and strobe are stable mid cycle
    always @(negedge camClock) begin
        if (rstN && wordValid) begin
            gotWords.push_back(edgeWord);
        end
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: tests still running after %0d ns", watchdogNs);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Edge bit of pixel (r,c), the window ends at that pixel
    function automatic logic modelBit(input int r, c, input sobelPkg::thresholdT thr);
        int gx;
        int gy;
        if (r < 2 || c < 2) begin
            return 1'b0;
        end
        gx = int'(image[r-2][c]) + 2 * int'(image[r-1][c]) + int'(image[r][c])
            - int'(image[r-2][c-2]) - 2 * int'(image[r-1][c-2]) - int'(image[r][c-2]);
        gy = int'(image[r-2][c-2]) + 2 * int'(image[r-2][c-1]) + int'(image[r-2][c])
            - int'(image[r][c-2]) - 2 * int'(image[r][c-1]) - int'(image[r][c]);
        return ((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy)) > int'(thr);
    endfunction

    // Write flag and register select in operand A
    function automatic logic [31:0] opWord(input logic write, input sobelPkg::ciRegT sel);
        logic [31:0] op;
        op = 32'd0;
        op[`SOBEL_OP_LSB] = write;
        op[`SOBEL_OP_LSB+1 +: 3] = sel;
        return op;
    endfunction

    task automatic stepCycle(input int n);
        repeat (n) begin
            @(posedge camClock);
            #1;
        end
    endtask

    task automatic checkWord(input logic [wordW-1:0] expected, got, input string what);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %h got %h", $time, what, expected, got);
        end
    endtask

    task automatic checkResult(input logic expDone, input logic [31:0] expected,
                               input logic gotDone, input logic [31:0] got, input string what);
        checkCount++;
        if (gotDone !== expDone || got !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected done %b result %h got done %b result %h",
                     $time, what, expDone, expected, gotDone, got);
        end
    endtask

    // Done and result are combinational in the start cycle
    task automatic instr(input logic [7:0] id, input logic [31:0] a, b,
                         input logic expDone, input logic [31:0] expected, input string what);
        logic done;
        logic [31:0] result;
        ciN = id;
        ciValueA = a;
        ciValueB = b;
        ciStart = 1'b1;
        @(negedge camClock);
        done = ciDone;
        result = ciResult;
        stepCycle(1);
        ciStart = 1'b0;
        checkResult(expDone, expected, done, result, what);
    endtask

    task automatic readStatus(input logic [31:0] expected, input string what);
        instr(ourId, opWord(1'b0, sobelPkg::REG_CAPTURE), 32'd0, 1'b1, expected, what);
    endtask

    task automatic fillImage(input logic step);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                rngState = xorshift(rngState);
                image[r][c] = step ? ((c < cols / 2) ? 8'd0 : 8'd255) : rngState[7:0];
            end
        end
    endtask

    // vsync, then each line followed by its hsync
    task automatic streamFrame();
        vsync = 1'b1;
        stepCycle(1);
        vsync = 1'b0;
        stepCycle(2);
        for (int r = 0; r < rows; r++) begin
            pixelValid = 1'b1;
            for (int c = 0; c < cols; c++) begin
                camData = image[r][c];
                stepCycle(1);
            end
            pixelValid = 1'b0;
            stepCycle(lineGap);
            hsync = 1'b1;
            stepCycle(1);
            hsync = 1'b0;
        end
        stepCycle(4);
    endtask

    task automatic compareWords(input string what);
        checkCount++;
        if (gotWords.size() != expWords.size()) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %0d words got %0d", $time, what,
                     expWords.size(), gotWords.size());
        end
        for (int i = 0; i < expWords.size() && i < gotWords.size(); i++) begin
            checkWord(expWords[i], gotWords[i], $sformatf("%s word %0d", what, i));
        end
    endtask

    // Set threshold, optionally arm, stream one frame and compare
    task automatic captureFrame(input logic arm, step, input sobelPkg::thresholdT thr,
                                input string what);
        logic [wordW-1:0] word;
        instr(ourId, opWord(1'b1, sobelPkg::REG_THRESHOLD), 32'(thr), 1'b1, 32'd0,
              "threshold write");
        if (arm) begin
            instr(ourId, opWord(1'b1, sobelPkg::REG_CAPTURE), 32'd0, 1'b1, 32'd0, "arm");
        end
        fillImage(step);
        expWords.delete();
        gotWords.delete();
        for (int r = 0; r < rows && arm; r++) begin
            for (int g = 0; g < cols / wordW; g++) begin
                // First pixel of a group lands in the MSB
                for (int b = 0; b < wordW; b++) begin
                    word[wordW-1-b] = modelBit(r, g * wordW + b, thr);
                end
                expWords.push_back(word);
            end
        end
        streamFrame();
        compareWords(what);
    endtask

    task automatic registerAccess();
        instr(ourId, opWord(1'b0, sobelPkg::REG_THRESHOLD), 32'd0, 1'b1, 32'd0, "reset threshold");
        readStatus(32'd0, "reset status");
        instr(ourId, opWord(1'b1, sobelPkg::REG_THRESHOLD), 32'h1234, 1'b1, 32'd0, "write");
        instr(ourId, opWord(1'b0, sobelPkg::REG_THRESHOLD), 32'd0, 1'b1, 32'h1234, "read");
        // Other instruction numbers are ignored
        instr(8'd6, opWord(1'b1, sobelPkg::REG_THRESHOLD), 32'h55, 1'b0, 32'd0, "foreign write");
        instr(8'd6, opWord(1'b0, sobelPkg::REG_THRESHOLD), 32'd0, 1'b0, 32'd0, "foreign read");
        instr(ourId, opWord(1'b0, sobelPkg::REG_THRESHOLD), 32'd0, 1'b1, 32'h1234, "kept");
    endtask

    task automatic unarmedFrame();
        captureFrame(1'b0, 1'b0, 16'd200, "unarmed frame");
        readStatus(32'd0, "status unarmed");
    endtask

    task automatic armedCapture();
        captureFrame(1'b1, 1'b0, 16'd200, "armed capture");
        // Two rows per line pair, no full window yet
        for (int i = 0; i < 4 && i < gotWords.size(); i++) begin
            checkWord('0, gotWords[i], "top rows");
        end
        readStatus(32'd2, "status in captured frame");
    endtask

    task automatic oneShot();
        captureFrame(1'b0, 1'b0, 16'd200, "second frame");
        readStatus(32'd0, "status after one-shot");
    endtask

    task automatic thresholdStep();
        captureFrame(1'b1, 1'b1, 16'd0, "step threshold 0");
        // Step at column 32 lights columns 32 and 33
        if (gotWords.size() == 12) begin
            checkWord(32'hc000_0000, gotWords[11], "step word");
        end
        captureFrame(1'b1, 1'b1, 16'hffff, "step threshold max");
    endtask

    initial begin
        int assertFails;
        camData = '0;
        pixelValid = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        ciStart = 1'b0;
        ciN = 8'd0;
        ciValueA = 32'd0;
        ciValueB = 32'd0;
        rstN = 1'b0;
        errorCount = 0;
        checkCount = 0;
        rngState = 32'hce2c_96ca;
        repeat (3) @(posedge camClock);
        #1;
        rstN = 1'b1;
        stepCycle(1);
        registerAccess();
        unarmedFrame();
        armedCapture();
        oneShot();
        thresholdStep();
        assertFails = dut.packer.packerChk.failCount + dut.regs.regsChk.failCount;
        if (assertFails != 0) begin
            errorCount += assertFails;
            $display("Bound checker saw %0d assertion failures", assertFails);
        end
        $display("Finished: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/sobelPkg.sv
verilog/phaseTracker.sv
verilog/sobelTap.sv
verilog/edgePacker.sv
verilog/controlRegs.sv
verilog/sobelTop.sv
bench/sobel_chk.sv
bench/sobelTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Sobel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module sobelTb -f project.f -o simv

# Assertion errors must not stop the run before the summary
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation passed"
